// ==== Makefile ====
# Verilator flow for the pipeline trace unit

TB_TOP := tb_pipe_trace_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module pipe_trace_unit \
		hw/trace_pkg.sv hw/trace_stage_tracker.sv hw/trace_record_fifo.sv \
		hw/trace_wb_slave.sv hw/pipe_trace_unit.sv

sim:
	verilator --binary --timing --assert -f pipe_trace_unit.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/pipe_trace_unit.sv ====
////////////////////////////////////////////////////////////
// top level of the pipeline trace unit
// stage tracker feeding the record buffer,
// host access through the wishbone slave
////////////////////////////////////////////////////////////

module pipe_trace_unit
    import trace_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    // cpu side
    input  logic                fetch_valid,
    input  logic [instr_w-1:0]  fetch_instr,
    input  logic                stall,
    input  logic                flush,
    // host side
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [wb_adr_w-1:0] wb_adr,
    input  logic [wb_dat_w-1:0] wb_dat_i,
    output logic [wb_dat_w-1:0] wb_dat_o,
    output logic                wb_ack
);

    // tracker to buffer
    logic             retire_valid;
    trace_rec_t       retire_rec;

    // buffer to slave
    trace_rec_t       head_rec;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] drop_count;
    logic             pop;

    trace_stage_tracker i_tracker (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .stall        (stall),
        .flush        (flush),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    trace_record_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (retire_valid),
        .push_rec   (retire_rec),
        .pop        (pop),
        .head_rec   (head_rec),
        .count      (count),
        .drop_count (drop_count)
    );

    trace_wb_slave i_wb (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .head_rec   (head_rec),
        .count      (count),
        .drop_count (drop_count),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .pop        (pop)
    );

endmodule

// ==== hw/trace_pkg.sv ====
////////////////////////////////////////////////////////////
// shared definitions for the pipeline trace unit
// field widths, retired-record layout and the
// wishbone register map of the host port
////////////////////////////////////////////////////////////

package trace_pkg;

    // basic widths
    localparam int instr_w  = 32;
    // sequence ids wrap at 256
    localparam int id_w     = 8;
    // cycle stamps and cycle counter wrap together
    localparam int stamp_w  = 16;
    // occupancy and drop counter fields in status
    localparam int cnt_w    = 8;

    // wishbone port geometry, word addressed
    localparam int wb_dat_w = 32;
    localparam int wb_adr_w = 3;

    // one retired instruction
    typedef struct packed {
        logic [instr_w-1:0] instr;
        logic [id_w-1:0]    id;
        // stamp taken when entering decode
        logic [stamp_w-1:0] id_stamp;
        logic [stamp_w-1:0] ex_stamp;
        logic [stamp_w-1:0] mem_stamp;
        logic [stamp_w-1:0] wb_stamp;
    } trace_rec_t;

    ////////////////////////////////////////////////////////////
    // register word addresses
    ////////////////////////////////////////////////////////////
    localparam logic [wb_adr_w-1:0] reg_status   = 3'd0;
    localparam logic [wb_adr_w-1:0] reg_instr    = 3'd1;
    localparam logic [wb_adr_w-1:0] reg_id_stamp = 3'd2;
    localparam logic [wb_adr_w-1:0] reg_ex_mem   = 3'd3;
    localparam logic [wb_adr_w-1:0] reg_wb       = 3'd4;
    localparam logic [wb_adr_w-1:0] reg_pop      = 3'd5;

endpackage

// ==== hw/trace_record_fifo.sv ====
////////////////////////////////////////////////////////////
// record buffer of the trace unit
// circular buffer of retired records with occupancy
// and a saturating counter of records lost when full
////////////////////////////////////////////////////////////

module trace_record_fifo
    import trace_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  trace_rec_t       push_rec,
    input  logic             pop,
    output trace_rec_t       head_rec,
    output logic [cnt_w-1:0] count,
    output logic [cnt_w-1:0] drop_count
);

    localparam int ptr_w = $clog2(FIFO_DEPTH);

    trace_rec_t       mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    // one extra bit so full and empty differ
    logic [ptr_w:0]   occ;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full    = occ == (ptr_w + 1)'(FIFO_DEPTH);
    assign empty   = occ == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers, occupancy, drops
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ        <= '0;
            drop_count <= '0;
        end else begin
            // pointers wrap by width, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
            // record lost, stick at all ones
            if (push && full && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    assign head_rec = mem[rd_ptr];
    assign count    = cnt_w'(occ);

    a_occ_bound : assert property (@(posedge clk) disable iff (rst)
        occ <= (ptr_w + 1)'(FIFO_DEPTH))
        else $error("occ over depth: occ=%h", occ);

    // slave only pops a nonempty buffer
    a_pop_nonempty : assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("pop while empty: occ=%h", occ);

endmodule

// ==== hw/trace_stage_tracker.sv ====
////////////////////////////////////////////////////////////
// stage tracker of the trace unit
// follows instructions through fetch, decode, execute,
// memory and write-back under stall and flush, stamps
// each stage entry and emits one record on retirement
////////////////////////////////////////////////////////////

module trace_stage_tracker
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  logic [instr_w-1:0] fetch_instr,
    input  logic               stall,
    input  logic               flush,
    output logic               retire_valid,
    output trace_rec_t         retire_rec
);

    // slot index: 0 fetch, 1 decode, 2 execute, 3 memory, 4 write-back
    localparam int n_slots = 5;

    logic [n_slots-1:0] slot_vld;
    trace_rec_t         slot_rec [n_slots];

    // free-running stamp source
    logic [stamp_w-1:0] cyc_cnt;
    // next id handed to an accepted fetch
    logic [id_w-1:0]    id_cnt;

    // flush wins over stall
    logic advance;

    // last retired id, only for the ordering check
    logic [id_w-1:0] last_ret_id;
    logic            have_ret;

    assign advance = !stall || flush;

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt <= '0;
            id_cnt  <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
            // ids only move for instructions actually taken in
            if (advance && fetch_valid) begin
                id_cnt <= id_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // slot valid chain
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_vld <= '0;
        end else if (advance) begin
            slot_vld[0] <= fetch_valid;
            // squash whatever leaves fetch and decode
            slot_vld[1] <= slot_vld[0] && !flush;
            slot_vld[2] <= slot_vld[1] && !flush;
            slot_vld[3] <= slot_vld[2];
            slot_vld[4] <= slot_vld[3];
        end
    end

    // slot payload, stamp written on entry to each stage
    always_ff @(posedge clk) begin
        if (advance) begin
            slot_rec[0]       <= '0;
            slot_rec[0].instr <= fetch_instr;
            slot_rec[0].id    <= id_cnt;

            slot_rec[1]          <= slot_rec[0];
            slot_rec[1].id_stamp <= cyc_cnt;

            slot_rec[2]          <= slot_rec[1];
            slot_rec[2].ex_stamp <= cyc_cnt;

            slot_rec[3]           <= slot_rec[2];
            slot_rec[3].mem_stamp <= cyc_cnt;

            slot_rec[4]          <= slot_rec[3];
            slot_rec[4].wb_stamp <= cyc_cnt;
        end
    end

    // record leaves write-back on the advancing edge
    assign retire_valid = slot_vld[n_slots-1] && advance;
    assign retire_rec   = slot_rec[n_slots-1];

    ////////////////////////////////////////////////////////////
    // retirement order check
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            have_ret <= 1'b0;
        end else if (retire_valid) begin
            have_ret <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_valid) begin
            last_ret_id <= retire_rec.id;
        end
    end

    // ids move forward, squashed ones leave a gap but never a repeat
    a_retire_id_order : assert property (@(posedge clk) disable iff (rst)
        retire_valid && have_ret |-> id_w'(retire_rec.id - last_ret_id) != '0)
        else $error("retire_rec.id repeat: id=%h last=%h", retire_rec.id, last_ret_id);

endmodule

// ==== hw/trace_wb_slave.sv ====
////////////////////////////////////////////////////////////
// wishbone classic register port of the trace unit
// status, head record words and the pop register
// registered read data and single-cycle ack
////////////////////////////////////////////////////////////

module trace_wb_slave
    import trace_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [wb_adr_w-1:0] wb_adr,
    input  logic [wb_dat_w-1:0] wb_dat_i,
    input  trace_rec_t          head_rec,
    input  logic [cnt_w-1:0]    count,
    input  logic [cnt_w-1:0]    drop_count,
    output logic [wb_dat_w-1:0] wb_dat_o,
    output logic                wb_ack,
    output logic                pop
);

    logic                req;
    logic                fifo_empty;
    logic [wb_dat_w-1:0] rd_data;

    // new request, not the cycle already being acked
    assign req        = wb_cyc && wb_stb && !wb_ack;
    assign fifo_empty = count == '0;

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (wb_adr)
            reg_status:   rd_data = {16'h0, drop_count, count};
            reg_instr:    rd_data = head_rec.instr;
            // id above the decode stamp
            reg_id_stamp: rd_data = {8'h0, head_rec.id, head_rec.id_stamp};
            // execute stamp high, memory stamp low
            reg_ex_mem:   rd_data = {head_rec.ex_stamp, head_rec.mem_stamp};
            reg_wb:       rd_data = {16'h0, head_rec.wb_stamp};
            default:      rd_data = '0;
        endcase
        // head is stale when nothing is buffered
        if (fifo_empty && wb_adr != reg_status) begin
            rd_data = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // ack and pop strobe
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            pop    <= 1'b0;
        end else begin
            wb_ack <= req;
            // any write to the pop word, data ignored
            pop    <= req && wb_we && wb_adr == reg_pop && !fifo_empty;
        end
    end

    // read data held until the next read
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_o <= rd_data;
        end
    end

    a_ack_follows_req : assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without request: cyc=%h stb=%h", $past(wb_cyc), $past(wb_stb));

    // master must present defined data on a write
    a_write_data_known : assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_stb && wb_we |-> !$isunknown(wb_dat_i))
        else $error("wb_dat_i unknown on write: %h", wb_dat_i);

endmodule

// ==== pipe_trace_unit.f ====
hw/trace_pkg.sv
hw/trace_stage_tracker.sv
hw/trace_record_fifo.sv
hw/trace_wb_slave.sv
hw/pipe_trace_unit.sv
tests/tb_pipe_trace_unit.sv

// ==== tests/tb_pipe_trace_unit.sv ====
////////////////////////////////////////////////////////////
// testbench of the pipeline trace unit
// clock, reset, cpu-side stimulus with seeded stalls,
// behavioral pipeline and buffer model, wishbone tasks
// and the six behavior tests with assertion checks
////////////////////////////////////////////////////////////

module tb_pipe_trace_unit
    import trace_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth = 8;

    logic                clk = 1'b0;
    logic                rst;
    logic                fetch_valid;
    logic [instr_w-1:0]  fetch_instr;
    logic                stall;
    logic                flush;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [wb_adr_w-1:0] wb_adr;
    logic [wb_dat_w-1:0] wb_dat_i;
    logic [wb_dat_w-1:0] wb_dat_o;
    logic                wb_ack;

    // model slots from 0 fetch up to 4 write-back
    trace_rec_t    m_rec [5];
    logic [4:0]    m_vld;
    logic [15:0]   m_cyc;
    logic [7:0]    m_next_id;
    int            m_retired;
    int            m_drop;
    trace_rec_t    exp_q [$];

    // ids seen on the bus and ids the rules predict
    int got_ids [$];
    int exp_ids [$];

    int errors;
    int test_err0;
    int tests_run;
    int tests_failed;

    always #20 clk = ~clk;

    pipe_trace_unit #(
        .FIFO_DEPTH (depth)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .flush       (flush),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack)
    );

    ////////////////////////////////////////////////////////////
    // reference model of the pipeline rules
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            m_vld     = '0;
            m_cyc     = '0;
            m_next_id = '0;
            m_retired = 0;
            m_drop    = 0;
            exp_q.delete();
        end else begin
            if (!stall || flush) begin
                // retiring records fill the buffer up to depth
                if (m_vld[4]) begin
                    m_retired++;
                    if (exp_q.size() < depth) begin
                        exp_q.push_back(m_rec[4]);
                    end else if (m_drop < 255) begin
                        m_drop++;
                    end
                end
                // oldest stage first so each takes the old neighbour
                m_rec[4] = m_rec[3];
                m_rec[4].wb_stamp = m_cyc;
                m_vld[4] = m_vld[3];
                m_rec[3] = m_rec[2];
                m_rec[3].mem_stamp = m_cyc;
                m_vld[3] = m_vld[2];
                m_rec[2] = m_rec[1];
                m_rec[2].ex_stamp = m_cyc;
                m_vld[2] = m_vld[1] && !flush;
                m_rec[1] = m_rec[0];
                m_rec[1].id_stamp = m_cyc;
                m_vld[1] = m_vld[0] && !flush;
                m_rec[0] = '0;
                m_rec[0].instr = fetch_instr;
                m_rec[0].id = m_next_id;
                m_vld[0] = fetch_valid;
                if (fetch_valid) begin
                    m_next_id++;
                end
            end
            m_cyc++;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks and bus access
    ////////////////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // called and left 2 ns after a rising edge
    task automatic bus_xfer(input logic we, input logic [wb_adr_w-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdat;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!wb_ack && n < 10);
        assert (wb_ack) else begin
            $display("timeout: no wb_ack for access to word %0d", adr);
            errors++;
        end
        assert (n == 1) else begin
            $display("wb_ack came %0d cycles after the request instead of 1", n);
            errors++;
        end
        rdat   = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #2;
        // exactly one ack per access
        assert (!wb_ack) else begin
            $display("wb_ack held for more than one cycle");
            errors++;
        end
    endtask

    task automatic bus_read(input logic [wb_adr_w-1:0] adr, output logic [31:0] d);
        bus_xfer(1'b0, adr, 32'h0, d);
    endtask

    task automatic bus_write(input logic [wb_adr_w-1:0] adr);
        logic [31:0] unused;
        bus_xfer(1'b1, adr, 32'h0000_0001, unused);
    endtask

    task automatic check_status();
        logic [31:0] d;
        bus_read(reg_status, d);
        check_val("status.count", 32'(d[7:0]), 32'(exp_q.size()));
        check_val("status.drop_count", 32'(d[15:8]), 32'(m_drop));
    endtask

    // read the head record word by word and pop it
    task automatic pop_record(input bit unit_gaps);
        trace_rec_t  e;
        logic [31:0] d;
        logic [15:0] id_st;
        logic [15:0] ex_st;
        logic [15:0] mem_st;
        logic [15:0] wb_st;
        e = exp_q[0];
        bus_read(reg_instr, d);
        check_val("instr", d, e.instr);
        bus_read(reg_id_stamp, d);
        check_val("id", 32'(d[23:16]), 32'(e.id));
        got_ids.push_back(int'(d[23:16]));
        id_st = d[15:0];
        bus_read(reg_ex_mem, d);
        ex_st  = d[31:16];
        mem_st = d[15:0];
        bus_read(reg_wb, d);
        wb_st = d[15:0];
        check_val("id_stamp", 32'(id_st), 32'(e.id_stamp));
        check_val("ex_stamp", 32'(ex_st), 32'(e.ex_stamp));
        check_val("mem_stamp", 32'(mem_st), 32'(e.mem_stamp));
        check_val("wb_stamp", 32'(wb_st), 32'(e.wb_stamp));
        // no stall means one cycle per stage
        if (unit_gaps) begin
            check_val("ex_stamp gap", 32'(16'(ex_st - id_st)), 32'd1);
            check_val("mem_stamp gap", 32'(16'(mem_st - ex_st)), 32'd1);
            check_val("wb_stamp gap", 32'(16'(wb_st - mem_st)), 32'd1);
        end
        bus_write(reg_pop);
        void'(exp_q.pop_front());
    endtask

    task automatic drain_all(input bit unit_gaps);
        int guard;
        guard = 0;
        got_ids.delete();
        check_status();
        while (exp_q.size() > 0 && guard < 32) begin
            pop_record(unit_gaps);
            guard++;
        end
        check_status();
    endtask

    task automatic check_ids();
        check_val("record total", 32'(got_ids.size()), 32'(exp_ids.size()));
        for (int i = 0; i < exp_ids.size() && i < got_ids.size(); i++) begin
            check_val("retired id", 32'(got_ids[i]), 32'(exp_ids[i]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cpu-side stimulus
    ////////////////////////////////////////////////////////////
    // offer n instructions with stall_pct percent stalled cycles
    task automatic send_instrs(input int n, input int stall_pct);
        int   acc;
        int   guard;
        logic s;
        acc = 0;
        guard = 0;
        fetch_instr = $urandom;
        while (acc < n && guard < 1000) begin
            s = ($urandom % 100) < stall_pct;
            fetch_valid = 1'b1;
            stall = s;
            @(posedge clk);
            #2;
            if (!s) begin
                acc++;
                fetch_instr = $urandom;
            end
            guard++;
        end
        assert (acc == n) else begin
            $display("timeout: only %0d of %0d instructions accepted", acc, n);
            errors++;
        end
        fetch_valid = 1'b0;
        stall = 1'b0;
    endtask

    task automatic wait_retired(input int target);
        int n;
        n = 0;
        while (m_retired < target && n < 200) begin
            @(posedge clk);
            #2;
            n++;
        end
        assert (m_retired >= target) else begin
            $display("timeout: only %0d instructions retired, waiting for %0d", m_retired, target);
            errors++;
        end
    endtask

    task automatic start_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] d;
        logic [7:0]  base;
        int          r0;
        void'($urandom(32'h9505_6334));
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset state and empty record reads
        start_test();
        bus_read(reg_status, d);
        check_val("status", d, 32'h0);
        bus_read(reg_instr, d);
        check_val("empty instr", d, 32'h0);
        bus_read(reg_wb, d);
        check_val("empty wb", d, 32'h0);
        end_test("reset state");

        start_test();
        send_instrs(6, 0);
        wait_retired(6);
        drain_all(1'b1);
        exp_ids.delete();
        for (int i = 0; i < 6; i++) begin
            exp_ids.push_back(i);
        end
        check_ids();
        end_test("free flow");

        // batches of five so the buffer never fills
        start_test();
        for (int b = 0; b < 4; b++) begin
            r0 = m_retired;
            send_instrs(5, 40);
            wait_retired(r0 + 5);
            drain_all(1'b0);
        end
        end_test("random stalls");

        // flush while base+3 sits in fetch and base+2 in decode
        start_test();
        r0 = m_retired;
        base = m_next_id;
        send_instrs(4, 0);
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        send_instrs(2, 0);
        wait_retired(r0 + 4);
        drain_all(1'b0);
        exp_ids.delete();
        exp_ids.push_back(int'(base));
        exp_ids.push_back(int'(8'(base + 1)));
        exp_ids.push_back(int'(8'(base + 4)));
        exp_ids.push_back(int'(8'(base + 5)));
        check_ids();
        end_test("flush");

        start_test();
        r0 = m_retired;
        base = m_next_id;
        send_instrs(12, 0);
        wait_retired(r0 + 12);
        bus_read(reg_status, d);
        check_val("status.count", 32'(d[7:0]), 32'd8);
        check_val("status.drop_count", 32'(d[15:8]), 32'd4);
        drain_all(1'b1);
        exp_ids.delete();
        for (int i = 0; i < 8; i++) begin
            exp_ids.push_back(int'(8'(base + 8'(i))));
        end
        check_ids();
        end_test("overflow");

        // pop on an empty buffer changes nothing
        start_test();
        bus_read(reg_status, d);
        check_val("status", d, {16'h0, 8'(m_drop), 8'h00});
        bus_write(reg_pop);
        bus_read(reg_status, d);
        check_val("status", d, {16'h0, 8'(m_drop), 8'h00});
        end_test("pop protocol");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
